//--- all.f
verilog/obj_pkg.sv
verilog/video_if.sv
verilog/obj_timing.sv
verilog/obj_desc_ram.sv
verilog/obj_gfx_ram.sv
verilog/obj_draw.sv
verilog/obj_video_top.sv
tests/obj_asserts.sv
tests/obj_tb.sv

//--- run.sh
#!/bin/sh
# Build the object layer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module obj_tb --Mdir obj_dir -o obj_sim -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Error limit raised so the testbench itself can report a bound assertion failure
sim_out=$(./obj_dir/obj_sim +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "Pass line missing from simulation output"
exit 1

//--- tests/obj_tb.sv
/* Object layer testbench
   Random RAM contents, line model of the drawer, per sample compare */
`timescale 1ns/1ps
`default_nettype none

module obj_tb
    import obj_pkg::*;
();

    localparam int H_TOTAL    = 288;
    localparam int H_ACTIVE   = 256;
    localparam int V_TOTAL    = 24;
    localparam int V_ACTIVE   = 20;
    localparam int FRAME_CLKS = 2 * H_TOTAL * V_TOTAL;   // Two clocks per pixel
    localparam int TIMEOUT    = 2 * FRAME_CLKS;

    logic               clk;
    logic               reset;
    logic               desc_we;
    logic [SLOT_AW-1:0] desc_waddr;
    obj_desc_t          desc_wdata;
    logic               gfx_we;
    logic [GFX_AW-1:0]  gfx_waddr;
    gfx_row_t           gfx_wdata;
    logic [1:0]         obj_pix;
    logic [PAL_W-1:0]   pix_pal;
    logic [8:0]         pix_h;
    logic [8:0]         pix_v;
    logic               pix_sub;
    logic               pix_hb;
    logic               pix_vb;

    obj_desc_t desc_mem [1 << SLOT_AW];   // Model copies of both RAMs
    gfx_row_t  gfx_mem [1 << GFX_AW];
    logic      checking;
    string     test_name;
    logic [8:0] pos_h;                    // Position of the next sample to compare
    logic [8:0] pos_v;
    logic       pos_sub;
    int        n_shown0;                  // Coverage of the drawing cases
    int        n_shown1;
    int        n_zero;
    int        n_blank;

    obj_video_top #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .desc_we    (desc_we),
        .desc_waddr (desc_waddr),
        .desc_wdata (desc_wdata),
        .gfx_we     (gfx_we),
        .gfx_waddr  (gfx_waddr),
        .gfx_wdata  (gfx_wdata),
        .obj_pix    (obj_pix),
        .pix_pal    (pix_pal),
        .pix_h      (pix_h),
        .pix_v      (pix_v),
        .pix_sub    (pix_sub),
        .pix_hb     (pix_hb),
        .pix_vb     (pix_vb)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_pix(input string name, input logic [1:0] exp_v, input logic [1:0] act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s pixel expected %0d actual %0d", name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_pal(input string name, input logic [PAL_W-1:0] exp_v,
                             input logic [PAL_W-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s palette expected %0d actual %0d", name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_blank(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s blank expected %0b actual %0b", name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_pos(input string name, input string what, input logic [8:0] exp_v,
                             input logic [8:0] act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s %s expected %0d actual %0d", name, what, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_sub(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s sub expected %0b actual %0b", name, exp_v, act_v);
            abort_run();
        end
    endtask

    // Expected {pal, pixel} for one 2x sample of line v
    function automatic logic [PAL_W+1:0] ref_sample(input logic [8:0] v, input logic [8:0] h,
                                                    input logic sub);
        obj_desc_t  d;
        gfx_row_t   r;
        logic [7:0] diff;
        logic [3:0] k;
        logic [3:0] b;
        logic [1:0] pix;
        d    = desc_mem[h[SLOT_AW+2:3]];
        diff = v[7:0] - {d.y, 2'b00};      // Line inside the object, wraps at 256
        k    = {h[2:0], sub};              // Sample number inside the slot
        b    = d.hflip ? 4'd15 - k : k;
        r    = gfx_mem[{d.id, diff[ROW_W-1:0]}];
        pix  = {r.plane1[b], r.plane0[b]};
        if (h >= 9'(H_ACTIVE) || v >= 9'(V_ACTIVE) || diff[7:ROW_W] != '0) begin
            pix = 2'b00;
        end
        return {d.pal, pix};
    endfunction

    function automatic obj_desc_t random_desc();
        obj_desc_t d;
        d.id = 8'($urandom);
        if ($urandom % 4 == 0) begin
            d.y = 6'($urandom);         // Mostly off screen
        end else begin
            d.y = 6'($urandom % 7);     // 6 starts below the frame
        end
        d.pal   = 3'($urandom);
        d.hflip = 1'($urandom);
        return d;
    endfunction

    task automatic write_desc(input logic [SLOT_AW-1:0] slot, input obj_desc_t d);
        @(posedge clk);
        desc_mem[slot] = d;
        desc_we    <= 1'b1;
        desc_waddr <= slot;
        desc_wdata <= d;
    endtask

    // Sample on the falling edge, away from DUT updates
    task automatic wait_pix_vb(input logic level);
        int n;
        n = 0;
        while (pix_vb !== level) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("ERROR: vertical blank never %s, the frame never started",
                         level ? "began" : "ended");
                abort_run();
            end
        end
    endtask

    always @(negedge clk) begin : compare
        logic [PAL_W+1:0] exp_s;
        logic             exp_hb;
        logic             exp_vb;
        string            name;
        if (dut0.u_asserts.fail_cnt != 0) begin
            $display("ERROR: a bound assertion on the drawer failed");
            abort_run();
        end
        if (checking) begin
            exp_s  = ref_sample(pos_v, pos_h, pos_sub);
            exp_hb = (pos_h >= 9'(H_ACTIVE));
            exp_vb = (pos_v >= 9'(V_ACTIVE));
            name   = $sformatf("%s v=%0d h=%0d sub=%0d", test_name, pos_v, pos_h, pos_sub);
            check_pos(name, "v", pos_v, pix_v);
            check_pos(name, "h", pos_h, pix_h);
            check_sub(name, pos_sub, pix_sub);
            check_blank(name, exp_hb, pix_hb);
            check_blank(name, exp_vb, pix_vb);
            check_pix(name, exp_s[1:0], obj_pix);
            if (exp_hb || exp_vb) begin
                n_blank++;                        // Palette is don't care here
            end else begin
                check_pal(name, exp_s[PAL_W+1:2], pix_pal);
                if (exp_s[1:0] == 2'b00) n_zero++;
                else if (desc_mem[pos_h[SLOT_AW+2:3]].hflip) n_shown1++;
                else n_shown0++;
            end
            // Two samples per pixel, line count steps as hblank begins
            if (pos_sub) begin
                if (pos_h == 9'(H_ACTIVE - 1)) begin
                    pos_v = (pos_v == 9'(V_TOTAL - 1)) ? 9'd0 : pos_v + 9'd1;
                end
                pos_h = (pos_h == 9'(H_TOTAL - 1)) ? 9'd0 : pos_h + 9'd1;
            end
            pos_sub = ~pos_sub;
        end
    end

    initial begin
        gfx_row_t  row;
        obj_desc_t d;
        void'($urandom(32'h4cf67f75));
        reset      = 1'b1;
        desc_we    = 1'b0;
        desc_waddr = '0;
        desc_wdata = '0;
        gfx_we     = 1'b0;
        gfx_waddr  = '0;
        gfx_wdata  = '0;
        checking   = 1'b0;
        test_name  = "random_frame";
        pos_h      = '0;
        pos_v      = '0;
        pos_sub    = 1'b0;
        n_shown0   = 0;
        n_shown1   = 0;
        n_zero     = 0;
        n_blank    = 0;

        // Load both RAMs, reset drops after 16 clocks, frame 0 unchecked
        for (int i = 0; i < (1 << GFX_AW); i++) begin
            @(posedge clk);
            row.plane1 = 16'($urandom);
            row.plane0 = 16'($urandom);
            gfx_mem[i] = row;
            gfx_we    <= 1'b1;
            gfx_waddr <= GFX_AW'(i);
            gfx_wdata <= row;
            if (i < (1 << SLOT_AW)) begin
                d           = random_desc();
                desc_mem[i] = d;
                desc_we    <= 1'b1;
                desc_waddr <= SLOT_AW'(i);
                desc_wdata <= d;
            end else begin
                desc_we <= 1'b0;
            end
            if (i == 15) reset <= 1'b0;
        end
        @(posedge clk);
        gfx_we <= 1'b0;

        wait_pix_vb(1'b1);
        wait_pix_vb(1'b0);            // Line 0 opens with its hblank
        @(posedge clk);
        pos_v    = 9'd0;              // Second sample of the first hblank pixel
        pos_h    = 9'(H_ACTIVE);
        pos_sub  = 1'b1;
        checking = 1'b1;
        wait_pix_vb(1'b1);            // One full frame compared

        // New descriptors in vblank, every flip inverted, y spread over 0..7
        test_name = "rewrite_frame";
        for (int s = 0; s < (1 << SLOT_AW); s++) begin
            d       = desc_mem[s];
            d.hflip = ~d.hflip;
            d.y     = 6'((s * 3) % 8);
            d.pal   = 3'($urandom);
            write_desc(SLOT_AW'(s), d);
        end
        @(posedge clk);
        desc_we <= 1'b0;

        wait_pix_vb(1'b0);
        wait_pix_vb(1'b1);

        if (n_shown0 == 0 || n_shown1 == 0 || n_zero == 0 || n_blank == 0) begin
            $display("ERROR: a drawing case never occurred (%0d %0d %0d %0d)",
                     n_shown0, n_shown1, n_zero, n_blank);
            abort_run();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/obj_asserts.sv
/* Object layer assertions
   Pixel enable cadence, blanking of the pixel output, no fetch in vblank */
`timescale 1ns/1ps
`default_nettype none

module obj_asserts (
    input logic       clk,
    input logic       reset,
    input logic       pxl_cen,
    input logic       vb,         // Timing side vblank
    input logic       gfx_rd,
    input logic [1:0] obj_pix,
    input logic       pix_hb,
    input logic       pix_vb
);

    int unsigned fail_cnt = 0;    // Read by the testbench

    // Pixel enable strictly alternates
    cen_fall: assert property (@(posedge clk) disable iff (reset) pxl_cen |=> !pxl_cen)
        else begin fail_cnt++; $error("pxl_cen stayed high for two clocks"); end
    cen_rise: assert property (@(posedge clk) disable iff (reset) !pxl_cen |=> pxl_cen)
        else begin fail_cnt++; $error("pxl_cen stayed low for two clocks"); end

    blank_zero: assert property (@(posedge clk) disable iff (reset)
        (pix_hb || pix_vb) |-> (obj_pix == 2'b00))
        else begin fail_cnt++; $error("object pixel not zero in blanking"); end

    // Empty slots never fetch, vblank slots are all empty
    no_vb_fetch: assert property (@(posedge clk) disable iff (reset) vb |-> !gfx_rd)
        else begin fail_cnt++; $error("graphics read during vblank"); end

endmodule

bind obj_video_top obj_asserts u_asserts (
    .clk     (clk),
    .reset   (reset),
    .pxl_cen (vid.pxl_cen),
    .vb      (vid.vb),
    .gfx_rd  (gfx_rd),
    .obj_pix (obj_pix),
    .pix_hb  (pix_hb),
    .pix_vb  (pix_vb)
);

`default_nettype wire

//--- verilog/obj_video_top.sv
/* Object layer top level
   Timing, descriptor RAM, graphics RAM and drawer */
`timescale 1ns/1ps
`default_nettype none

module obj_video_top
    import obj_pkg::*;
#(
    parameter int H_TOTAL  = 320,
    parameter int H_ACTIVE = 256,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 240
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               desc_we,
    input  logic [SLOT_AW-1:0] desc_waddr,
    input  obj_desc_t          desc_wdata,
    input  logic               gfx_we,
    input  logic [GFX_AW-1:0]  gfx_waddr,
    input  gfx_row_t           gfx_wdata,
    output logic [1:0]         obj_pix,
    output logic [PAL_W-1:0]   pix_pal,
    output logic [8:0]         pix_h,
    output logic [8:0]         pix_v,
    output logic               pix_sub,
    output logic               pix_hb,
    output logic               pix_vb
);

    logic [SLOT_AW-1:0] desc_addr;
    obj_desc_t          desc_q;
    logic               gfx_rd;
    logic [GFX_AW-1:0]  gfx_addr;
    gfx_row_t           gfx_q;

    video_if vid ();

    obj_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE)
    ) u_timing (
        .clk   (clk),
        .reset (reset),
        .vid   (vid.src)
    );

    obj_desc_ram u_desc_ram (
        .clk   (clk),
        .we    (desc_we),
        .waddr (desc_waddr),
        .wdata (desc_wdata),
        .raddr (desc_addr),
        .q     (desc_q)
    );

    obj_gfx_ram u_gfx_ram (
        .clk   (clk),
        .we    (gfx_we),
        .waddr (gfx_waddr),
        .wdata (gfx_wdata),
        .rd    (gfx_rd),
        .raddr (gfx_addr),
        .q     (gfx_q)
    );

    obj_draw u_draw (
        .clk       (clk),
        .reset     (reset),
        .vid       (vid.snk),
        .desc_addr (desc_addr),
        .desc_q    (desc_q),
        .gfx_rd    (gfx_rd),
        .gfx_addr  (gfx_addr),
        .gfx_q     (gfx_q),
        .obj_pix   (obj_pix),
        .pix_pal   (pix_pal),
        .pix_h     (pix_h),
        .pix_v     (pix_v),
        .pix_sub   (pix_sub),
        .pix_hb    (pix_hb),
        .pix_vb    (pix_vb)
    );

endmodule

`default_nettype wire

//--- verilog/obj_draw.sv
/* Row based object drawer
   Per slot descriptor fetch, row test, plane shifters and pixel output */
`timescale 1ns/1ps
`default_nettype none

module obj_draw
    import obj_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    video_if.snk               vid,
    output logic [SLOT_AW-1:0] desc_addr,
    input  obj_desc_t          desc_q,
    output logic               gfx_rd,
    output logic [GFX_AW-1:0]  gfx_addr,
    input  gfx_row_t           gfx_q,
    output logic [1:0]         obj_pix,
    output logic [PAL_W-1:0]   pix_pal,
    output logic [8:0]         pix_h,
    output logic [8:0]         pix_v,
    output logic               pix_sub,
    output logic               pix_hb,
    output logic               pix_vb
);

    logic             slot_start;   // First 2x sample of a slot
    logic             test_ph;      // Phase 2, row test
    logic             fetch_ph;     // Phase 3, graphics read
    logic [7:0]       row_diff;     // v - 4*y, mod 256
    logic             vis_n;        // Next slot covers this line
    logic [PAL_W-1:0] pal_n;
    logic             hflip_n;
    logic [PAL_W-1:0] pal_a;        // Slot being shifted
    logic             hflip_a;
    gfx_row_t         row_ld;
    logic [15:0]      sh1;
    logic [15:0]      sh0;
    logic [1:0]       pix_nx;
    logic [8:0]       h_d1;
    logic [8:0]       v_d1;
    logic             sub_d1;
    logic             hb_d1;
    logic             vb_d1;

    assign slot_start = vid.pxl2_cen && !vid.pxl_cen && (vid.h[2:0] == 3'd0);
    assign test_ph    = vid.pxl_cen && (vid.h[2:0] == 3'd2);
    assign fetch_ph   = vid.pxl_cen && (vid.h[2:0] == 3'd3);

    // Next slot; whole hblank prefetches slot 0 of the coming line
    assign desc_addr = vid.hb ? '0 : vid.h[SLOT_AW+2:3] + 1'b1;

    assign row_diff = vid.v[7:0] - {desc_q.y, 2'b00};

    // No fetch for empty slots, so none in vblank either
    assign gfx_rd = fetch_ph && vis_n;

    assign row_ld = vis_n ? gfx_q : '0;    // Empty slot shifts zeros

    // hflip walks from bit 15 down
    assign pix_nx = hflip_a ? {sh1[15], sh0[15]} : {sh1[0], sh0[0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            vis_n <= 1'b0;
        end else if (test_ph) begin
            vis_n <= (row_diff[7:ROW_W] == '0) && !vid.vb;
        end
    end

    // Pending descriptor fields for the next slot
    always_ff @(posedge clk) begin
        if (test_ph) begin
            gfx_addr <= {desc_q.id, row_diff[ROW_W-1:0]};
            pal_n    <= desc_q.pal;
            hflip_n  <= desc_q.hflip;
        end
    end

    // Plane shifters, load at the slot boundary
    always_ff @(posedge clk) begin
        if (reset) begin
            sh1     <= '0;
            sh0     <= '0;
            pal_a   <= '0;
            hflip_a <= 1'b0;
        end else if (vid.pxl2_cen) begin
            if (slot_start) begin
                sh1     <= row_ld.plane1;
                sh0     <= row_ld.plane0;
                pal_a   <= pal_n;
                hflip_a <= hflip_n;
            end else if (hflip_a) begin
                sh1 <= {sh1[14:0], 1'b0};
                sh0 <= {sh0[14:0], 1'b0};
            end else begin
                sh1 <= {1'b0, sh1[15:1]};
                sh0 <= {1'b0, sh0[15:1]};
            end
        end
    end

    // Two clock delay on position and blanks, sample rides one behind
    always_ff @(posedge clk) begin
        if (reset) begin
            {h_d1, v_d1, sub_d1, hb_d1, vb_d1} <= '0;
            {pix_h, pix_v, pix_sub, pix_hb, pix_vb} <= '0;
            obj_pix <= '0;
            pix_pal <= '0;
        end else if (vid.pxl2_cen) begin
            h_d1    <= vid.h;
            v_d1    <= vid.v;
            sub_d1  <= vid.pxl_cen;   // High on second half of a pixel
            hb_d1   <= vid.hb;
            vb_d1   <= vid.vb;
            pix_h   <= h_d1;
            pix_v   <= v_d1;
            pix_sub <= sub_d1;
            pix_hb  <= hb_d1;
            pix_vb  <= vb_d1;
            obj_pix <= (hb_d1 || vb_d1) ? 2'b00 : pix_nx; // Blank forces zero
            pix_pal <= pal_a;
        end
    end

endmodule

`default_nettype wire

//--- verilog/obj_gfx_ram.sv
/* Object graphics RAM
   2048 rows of two planes, read register loads only on rd */
`timescale 1ns/1ps
`default_nettype none

module obj_gfx_ram
    import obj_pkg::*;
(
    input  logic              clk,
    input  logic              we,
    input  logic [GFX_AW-1:0] waddr,
    input  gfx_row_t          wdata,
    input  logic              rd,
    input  logic [GFX_AW-1:0] raddr,
    output gfx_row_t          q
);

    localparam int DEPTH = 1 << GFX_AW;

    gfx_row_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;    // Host load
        end
    end

    // Row stays put until the next fetch
    // shifter picks it up at the slot boundary
    always_ff @(posedge clk) begin
        if (rd) begin
            q <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/obj_desc_ram.sv
/* Object descriptor RAM
   32 slots, host write port and registered read port */
`timescale 1ns/1ps
`default_nettype none

module obj_desc_ram
    import obj_pkg::*;
(
    input  logic               clk,
    input  logic               we,
    input  logic [SLOT_AW-1:0] waddr,
    input  obj_desc_t          wdata,
    input  logic [SLOT_AW-1:0] raddr,
    output obj_desc_t          q
);

    localparam int DEPTH = 1 << SLOT_AW;

    obj_desc_t mem [DEPTH];

    // Host side, one word per clock
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Drawer side
    // address is held for a whole slot so q settles on the next clock
    always_ff @(posedge clk) begin
        q <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- verilog/obj_timing.sv
/* Video timing generator
   Pixel enables, H and V counters and blanking */
`timescale 1ns/1ps
`default_nettype none

module obj_timing #(
    parameter int H_TOTAL  = 320,
    parameter int H_ACTIVE = 256,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 240
) (
    input  logic  clk,
    input  logic  reset,
    video_if.src  vid
);

    logic       cen;
    logic [8:0] h_cnt;
    logic [8:0] v_cnt;
    logic       h_last;     // Last pixel of the line
    logic       h_act_end;  // Last active pixel
    logic       v_last;

    assign h_last    = (h_cnt == 9'(H_TOTAL - 1));
    assign h_act_end = (h_cnt == 9'(H_ACTIVE - 1));
    assign v_last    = (v_cnt == 9'(V_TOTAL - 1));

    // Each h is shown for two clocks, pxl_cen low then high
    always_ff @(posedge clk) begin
        if (reset) begin
            cen   <= 1'b0;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            cen <= ~cen;
            if (cen) begin
                h_cnt <= h_last ? 9'd0 : h_cnt + 9'd1;
                // Line count steps as hblank begins
                // so the blank interval already carries the next line
                if (h_act_end) begin
                    v_cnt <= v_last ? 9'd0 : v_cnt + 9'd1;
                end
            end
        end
    end

    assign vid.pxl_cen  = cen;
    assign vid.pxl2_cen = 1'b1;       // Shifter runs at 2x pixel rate
    assign vid.h        = h_cnt;
    assign vid.v        = v_cnt;
    assign vid.hb       = (h_cnt >= 9'(H_ACTIVE)); // Blank right of active area
    assign vid.vb       = (v_cnt >= 9'(V_ACTIVE));

endmodule

`default_nettype wire

//--- verilog/video_if.sv
/* Video timing bundle, timing generator to object drawer */
`timescale 1ns/1ps
`default_nettype none

interface video_if;
    logic       pxl_cen;    // Every second clock
    logic       pxl2_cen;   // Every clock
    logic [8:0] h;
    logic [8:0] v;          // Already on the next line during hblank
    logic       hb;
    logic       vb;

    modport src (
        output pxl_cen, pxl2_cen, h, v, hb, vb
    );

    modport snk (
        input pxl_cen, pxl2_cen, h, v, hb, vb
    );
endinterface

`default_nettype wire

//--- verilog/obj_pkg.sv
/* Object layer package
   Descriptor layout, graphics row layout and address widths */
`default_nettype none

package obj_pkg;

    localparam int OBJ_ID_W = 8;   // Object code width
    localparam int ROW_W    = 3;   // Row inside an 8-line object
    localparam int GFX_AW   = 11;  // {id, row}
    localparam int SLOT_AW  = 5;   // 32 slots of 8 pixels
    localparam int PAL_W    = 3;

    // One descriptor per column slot, 18 bits
    typedef struct packed {
        logic [OBJ_ID_W-1:0] id;     // Object code
        logic [5:0]          y;      // Top line / 4
        logic [PAL_W-1:0]    pal;
        logic                hflip;
    } obj_desc_t;

    // One graphics row, two bit planes
    typedef struct packed {
        logic [15:0] plane1;
        logic [15:0] plane0;     // Bit 0 is the leftmost sample unless flipped
    } gfx_row_t;

endpackage

`default_nettype wire
